//--- logic/fft_stage0_pkg.sv
package fft_stage0_pkg;

    // complex samples per row.
    localparam int LANES = 4;

    // rows in half a frame.
    localparam int HALF_ROWS = 8;

    // input part width.
    localparam int IN_W = 9;

    // one growth bit for the butterfly.
    localparam int OUT_W = IN_W + 1;

    // row memory address width.
    localparam int ROW_AW = $clog2(HALF_ROWS);

    // first butterfly row that takes the -j rotation.
    localparam int QUARTER_ROWS = HALF_ROWS / 2;

    // input sample.
    typedef struct packed {
        logic signed [IN_W-1:0] re;
        logic signed [IN_W-1:0] im;
    } cplx_in_t;

    // butterfly output sample.
    typedef struct packed {
        logic signed [OUT_W-1:0] re;
        logic signed [OUT_W-1:0] im;
    } cplx_out_t;

    // one row of lanes, lane 0 in the low bits.
    typedef cplx_in_t [LANES-1:0] row_in_t;

    // stored and output rows.
    typedef cplx_out_t [LANES-1:0] row_out_t;

endpackage

//--- logic/bf0_row_mem.sv
module bf0_row_mem
    import fft_stage0_pkg::*;
(
    input  logic              clk,
    input  logic [ROW_AW-1:0] waddr,
    input  logic [ROW_AW-1:0] raddr,
    input  logic              we,
    input  row_out_t          wdata,
    output row_out_t          rdata
);

    // one slot per row of a half frame.
    // holds first-half inputs, later overwritten by the differences.
    row_out_t mem [HALF_ROWS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // asynchronous read.
    // a read and a write of the same slot in one cycle returns the old row,
    // which the drain depends on when the next frame fills behind it.
    assign rdata = mem[raddr];

endmodule

//--- logic/bf0_stage_ctrl.sv
module bf0_stage_ctrl
    import fft_stage0_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              in_valid,
    output logic [ROW_AW-1:0] waddr,
    output logic [ROW_AW-1:0] raddr,
    output logic              we,
    output logic              wsel_diff,
    output logic              bf_en,
    output logic              apply_minus_j,
    output logic              out_valid,
    output logic              out_is_diff
);

    localparam logic [ROW_AW-1:0] LAST_ROW = ROW_AW'(HALF_ROWS - 1);
    localparam logic [ROW_AW-1:0] FIRST_ROT = ROW_AW'(QUARTER_ROWS);

    // row index within the current half.
    logic [ROW_AW-1:0] row_idx;
    // high during the second half of a frame.
    logic              second_half;

    // drain position and active bit.
    logic [ROW_AW-1:0] drain_idx;
    logic              drain_active;

    logic sum_valid_q;
    logic last_bf_q;

    assign bf_en = in_valid && second_half;
    assign apply_minus_j = bf_en && (row_idx >= FIRST_ROT);

    // the butterfly owns the read port when it runs.
    // that only overlaps the drain on its final slot.
    assign raddr = bf_en ? row_idx : drain_idx;

    assign out_valid = sum_valid_q || drain_active;
    assign out_is_diff = drain_active;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_idx     <= '0;
            second_half <= 1'b0;
        end else if (in_valid) begin
            if (row_idx == LAST_ROW) begin
                row_idx     <= '0;
                second_half <= !second_half;
            end else begin
                row_idx <= row_idx + 1'b1;
            end
        end
    end

    // every write lands one cycle after its row arrived.
    // fill rows then trail the drain by a cycle, and the difference
    // matches the butterfly register.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            we        <= 1'b0;
            waddr     <= '0;
            wsel_diff <= 1'b0;
        end else begin
            we        <= in_valid;
            waddr     <= row_idx;
            wsel_diff <= second_half;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sum_valid_q <= 1'b0;
            last_bf_q   <= 1'b0;
        end else begin
            sum_valid_q <= bf_en;
            last_bf_q   <= bf_en && (row_idx == LAST_ROW);
        end
    end

    // drain starts the cycle after the last sum.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            drain_idx    <= '0;
            drain_active <= 1'b0;
        end else if (last_bf_q) begin
            drain_idx    <= '0;
            drain_active <= 1'b1;
        end else if (drain_active) begin
            drain_idx <= drain_idx + 1'b1;
            if (drain_idx == LAST_ROW) begin
                drain_active <= 1'b0;
            end
        end
    end

endmodule

//--- logic/bf0_butterfly.sv
module bf0_butterfly
    import fft_stage0_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     en,
    input  logic     apply_minus_j,
    input  row_out_t sr_row,
    input  row_in_t  org_row,
    output row_out_t sum_row,
    output row_out_t diff_row
);

    row_out_t sum_c;
    row_out_t diff_c;

    // per-lane sum and difference.
    always_comb begin : bf_math
        logic signed [OUT_W-1:0] org_re;
        logic signed [OUT_W-1:0] org_im;
        logic signed [OUT_W-1:0] sub_re;
        logic signed [OUT_W-1:0] sub_im;

        for (int i = 0; i < LANES; i++) begin
            // sign extension to the output width.
            org_re = org_row[i].re;
            org_im = org_row[i].im;

            sum_c[i].re = sr_row[i].re + org_re;
            sum_c[i].im = sr_row[i].im + org_im;

            sub_re = sr_row[i].re - org_re;
            sub_im = sr_row[i].im - org_im;

            // multiply by -j.
            if (apply_minus_j) begin
                diff_c[i].re = sub_im;
                diff_c[i].im = -sub_re;
            end else begin
                diff_c[i].re = sub_re;
                diff_c[i].im = sub_im;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sum_row  <= '0;
            diff_row <= '0;
        end else if (en) begin
            sum_row  <= sum_c;
            diff_row <= diff_c;
        end
    end

endmodule

//--- logic/fft_stage0_top.sv
module fft_stage0_top
    import fft_stage0_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    input  row_in_t  in_row,
    output logic     out_valid,
    output logic     out_is_diff,
    output row_out_t out_row
);

    logic [ROW_AW-1:0] waddr;
    logic [ROW_AW-1:0] raddr;
    logic              we;
    logic              wsel_diff;
    logic              bf_en;
    logic              apply_minus_j;

    row_out_t in_ext;
    row_out_t in_row_q;
    row_out_t wdata;
    row_out_t rdata;
    row_out_t sum_row;
    row_out_t diff_row;

    // widen the input row for storage.
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            in_ext[i].re = in_row[i].re;
            in_ext[i].im = in_row[i].im;
        end
    end

    // fill rows are written a cycle late.
    always_ff @(posedge clk) begin
        in_row_q <= in_ext;
    end

    assign wdata = wsel_diff ? diff_row : in_row_q;

    // the last drain slot can coincide with the next frame's first butterfly
    // read. Its difference still sits in the butterfly register then.
    always_comb begin
        if (!out_is_diff) begin
            out_row = sum_row;
        end else if (bf_en) begin
            out_row = diff_row;
        end else begin
            out_row = rdata;
        end
    end

    bf0_stage_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .in_valid     (in_valid),
        .waddr        (waddr),
        .raddr        (raddr),
        .we           (we),
        .wsel_diff    (wsel_diff),
        .bf_en        (bf_en),
        .apply_minus_j(apply_minus_j),
        .out_valid    (out_valid),
        .out_is_diff  (out_is_diff)
    );

    bf0_row_mem u_mem (
        .clk  (clk),
        .waddr(waddr),
        .raddr(raddr),
        .we   (we),
        .wdata(wdata),
        .rdata(rdata)
    );

    bf0_butterfly u_bf (
        .clk          (clk),
        .rstn         (rstn),
        .en           (bf_en),
        .apply_minus_j(apply_minus_j),
        .sr_row       (rdata),
        .org_row      (in_row),
        .sum_row      (sum_row),
        .diff_row     (diff_row)
    );

endmodule

//--- tests/stage0_checker.sv
module stage0_checker
    import fft_stage0_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    input  row_in_t  in_row,
    input  logic     out_valid,
    input  logic     out_is_diff,
    input  row_out_t out_row,
    output int       value_errors,
    output int       protocol_errors,
    output int       frames_done
);

    // full precision, so a wrap in the DUT shows up as a mismatch.
    typedef struct packed {
        int re;
        int im;
    } cplx_int_t;

    typedef cplx_int_t [LANES-1:0] row_int_t;

    typedef struct packed {
        int       due;
        logic     is_diff;
        logic     last;
        row_int_t row;
    } expect_t;

    expect_t  pending[$];
    row_in_t  held [HALF_ROWS];
    row_int_t diffs [HALF_ROWS];
    int       row_pos;
    int       cyc;

    task automatic compare_value(input string name, input int exp_val, input int got_val);
        if (exp_val != got_val) begin
            $display("Fail %0t %s expected %0d got %0d", $time, name, exp_val, got_val);
            value_errors++;
        end
    endtask

    task automatic check_outputs();
        expect_t head;
        if (pending.size() > 0 && pending[0].due == cyc) begin
            head = pending.pop_front();
            if (!out_valid) begin
                $display("%0t: out_valid is low in the cycle where a %s row was due",
                         $time, head.is_diff ? "difference" : "sum");
                protocol_errors++;
            end else begin
                compare_value("out_is_diff", int'(head.is_diff), int'(out_is_diff));
                for (int i = 0; i < LANES; i++) begin
                    compare_value($sformatf("out_row[%0d].re", i), head.row[i].re,
                                  int'($signed(out_row[i].re)));
                    compare_value($sformatf("out_row[%0d].im", i), head.row[i].im,
                                  int'($signed(out_row[i].im)));
                end
            end
            if (head.last) begin
                frames_done++;
            end
        end else if (out_valid || out_is_diff) begin
            $display("%0t: output strobe is high but no row was due", $time);
            protocol_errors++;
        end
    endtask

    // x[k] sits in held and x[k+H] is the incoming row.
    task automatic absorb_input();
        int      k;
        int      a_re;
        int      a_im;
        int      b_re;
        int      b_im;
        int      d_re;
        int      d_im;
        expect_t e;
        if (in_valid) begin
            if (row_pos < HALF_ROWS) begin
                held[row_pos] = in_row;
            end else begin
                k = row_pos - HALF_ROWS;
                e.due = cyc + 1;
                e.is_diff = 1'b0;
                e.last = 1'b0;
                for (int i = 0; i < LANES; i++) begin
                    a_re = int'($signed(held[k][i].re));
                    a_im = int'($signed(held[k][i].im));
                    b_re = int'($signed(in_row[i].re));
                    b_im = int'($signed(in_row[i].im));
                    e.row[i].re = a_re + b_re;
                    e.row[i].im = a_im + b_im;
                    d_re = a_re - b_re;
                    d_im = a_im - b_im;
                    // second quarter is multiplied by -j.
                    if (k >= HALF_ROWS / 2) begin
                        diffs[k][i].re = d_im;
                        diffs[k][i].im = -d_re;
                    end else begin
                        diffs[k][i].re = d_re;
                        diffs[k][i].im = d_im;
                    end
                end
                pending.push_back(e);
                // differences follow the last sum back to back.
                if (k == HALF_ROWS - 1) begin
                    for (int j = 0; j < HALF_ROWS; j++) begin
                        e.due = cyc + 2 + j;
                        e.is_diff = 1'b1;
                        e.last = (j == HALF_ROWS - 1);
                        e.row = diffs[j];
                        pending.push_back(e);
                    end
                end
            end
            row_pos = (row_pos + 1) % (2 * HALF_ROWS);
        end
    endtask

    // inputs and outputs are both settled at the falling edge.
    always @(negedge clk) begin
        if (!rstn) begin
            if (out_valid || out_is_diff) begin
                $display("%0t: output strobe is high during reset", $time);
                protocol_errors++;
            end
            pending.delete();
            row_pos = 0;
            cyc = 0;
        end else begin
            cyc++;
            check_outputs();
            absorb_input();
        end
    end

endmodule

//--- tests/tb_fft_stage0.sv
module tb_fft_stage0
    import fft_stage0_pkg::*;
();

    localparam int FRAMES = 40;
    localparam int TIMEOUT_CYCLES = FRAMES * 2 * HALF_ROWS * 2 + 100;
    localparam logic [31:0] SEED = 32'h043e_8f28;

    logic     clk;
    logic     rstn;
    logic     in_valid;
    row_in_t  in_row;
    logic     out_valid;
    logic     out_is_diff;
    row_out_t out_row;

    int          value_errors;
    int          protocol_errors;
    int          frames_done;
    int          cycles;
    logic [31:0] lfsr;

    fft_stage0_top UUT (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_row     (in_row),
        .out_valid  (out_valid),
        .out_is_diff(out_is_diff),
        .out_row    (out_row)
    );

    stage0_checker scoreboard (
        .clk            (clk),
        .rstn           (rstn),
        .in_valid       (in_valid),
        .in_row         (in_row),
        .out_valid      (out_valid),
        .out_is_diff    (out_is_diff),
        .out_row        (out_row),
        .value_errors   (value_errors),
        .protocol_errors(protocol_errors),
        .frames_done    (frames_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // a quarter of the parts are forced to the range limits.
    task automatic draw_part(output logic signed [IN_W-1:0] p);
        logic [31:0] mode;
        logic [31:0] raw;
        take_bits(3, mode);
        if (mode == 0) begin
            p = {1'b0, {(IN_W - 1){1'b1}}};
        end else if (mode == 1) begin
            p = {1'b1, {(IN_W - 1){1'b0}}};
        end else begin
            take_bits(IN_W, raw);
            p = raw[IN_W-1:0];
        end
    endtask

    task automatic draw_row(output row_in_t r);
        logic signed [IN_W-1:0] re_part;
        logic signed [IN_W-1:0] im_part;
        for (int i = 0; i < LANES; i++) begin
            draw_part(re_part);
            draw_part(im_part);
            r[i].re = re_part;
            r[i].im = im_part;
        end
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_row   = '0;
    endtask

    task automatic drive_row(input row_in_t r);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_row   = r;
    endtask

    initial begin
        row_in_t     row;
        logic [31:0] gap;
        in_valid = 1'b0;
        in_row   = '0;
        rstn     = 1'b0;
        lfsr     = SEED;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int f = 0; f < FRAMES; f++) begin
            for (int r = 0; r < 2 * HALF_ROWS; r++) begin
                // every fourth frame follows the previous one with no gaps.
                if (f % 4 != 3) begin
                    // about one idle cycle in four.
                    take_bits(2, gap);
                    while (gap == 0) begin
                        drive_idle();
                        take_bits(2, gap);
                    end
                end
                draw_row(row);
                drive_row(row);
            end
        end
        drive_idle();
        wait (frames_done == FRAMES);
        // a few quiet cycles to catch stray outputs.
        repeat (4) @(posedge clk);
        $display("errors: value %0d, protocol %0d, frames checked %0d of %0d",
                 value_errors, protocol_errors, frames_done, FRAMES);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d frames checked",
                 cycles, frames_done, FRAMES);
        $display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- verilog.f
logic/fft_stage0_pkg.sv
logic/bf0_row_mem.sv
logic/bf0_stage_ctrl.sv
logic/bf0_butterfly.sv
logic/fft_stage0_top.sv
tests/stage0_checker.sv
tests/tb_fft_stage0.sv

//--- Makefile
TB_TOP = tb_fft_stage0

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module fft_stage0_top

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
